/* hw/fdc_pkg.sv */
// types, register map, status bit positions and timing constants of the fdc
package fdc_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [1:0]  reg_addr_t;
	typedef logic [11:0] lba_t;
	typedef logic [8:0]  buf_addr_t;
	typedef logic [1:0]  size_code_t;
	typedef logic [10:0] sect_len_t;
	typedef logic [15:0] delay_t;

	// ====================
	// host register map
	localparam reg_addr_t A_COMMAND = 2'd0;
	localparam reg_addr_t A_STATUS  = 2'd0;  // shares the command address
	localparam reg_addr_t A_TRACK   = 2'd1;
	localparam reg_addr_t A_SECTOR  = 2'd2;
	localparam reg_addr_t A_DATA    = 2'd3;

	// ====================
	// geometry and timing
	localparam int BLOCK_BYTES     = 512;
	localparam int MAX_TRACK       = 84;
	localparam int STEP_UNIT       = 16;   // cycles per ms of step rate, short for sim
	localparam int BYTE_GAP        = 4;
	localparam int WATCHDOG_CYCLES = 400;

	// ====================
	// status byte layout
	localparam int ST_BUSY        = 0;
	localparam int ST_DRQ         = 1;
	localparam int ST_LOST_TRK0   = 2;  // track 0 on type I, lost data otherwise
	localparam int ST_RNF         = 4;
	localparam int ST_HLD_WRFAULT = 5;  // head loaded on type I
	localparam int ST_WPROT       = 6;
	localparam int ST_NOT_READY   = 7;

endpackage

/* hw/fdc_buf_if.sv */
// interface for the controller side port of the sector buffer
`timescale 1ns/1ps

interface fdc_buf_if import fdc_pkg::*; ();

	buf_addr_t addr;   // byte within the block
	byte_t     wdata;
	logic      we;
	byte_t     rdata;  // one cycle after addr

	// controller side
	modport ctrl (output addr, output wdata, output we, input rdata);

	// buffer side
	modport mem (input addr, input wdata, input we, output rdata);

endinterface

/* hw/fdc_locator.sv */
// geometry lookup, image block number, offset in block and sector range check
`timescale 1ns/1ps

module fdc_locator import fdc_pkg::*; (
	input  logic       clk_sys,
	input  byte_t      track,
	input  byte_t      sector,
	input  size_code_t size_code,
	output lba_t       lba,
	output buf_addr_t  buf_offset,
	output sect_len_t  sector_len,
	output logic       sector_ok
);

	byte_t       spt;        // sectors per track
	logic [3:0]  len_shift;  // log2 of sector length
	logic [12:0] lin;
	logic [20:0] byte_off;

	always_comb begin
		case (size_code)
			2'd0: begin
				spt = 8'd26;
				len_shift = 4'd7;
			end
			2'd1: begin
				spt = 8'd16;
				len_shift = 4'd8;
			end
			default: begin  // code 3 falls back to 9x512
				spt = 8'd9;
				len_shift = 4'd9;
			end
		endcase
		lin = 13'(track) * 13'(spt) + 13'(sector) - 13'd1;
		byte_off = 21'(lin) << len_shift;
	end

	always_ff @(posedge clk_sys) begin
		lba        <= byte_off[20:9];
		buf_offset <= byte_off[8:0];
		sector_len <= sect_len_t'(1) << len_shift;
		sector_ok  <= sector != 8'd0 && sector <= spt && track <= byte_t'(MAX_TRACK);
	end

endmodule

/* hw/fdc_delay_timer.sv */
// loadable countdown with a one-cycle done pulse
`timescale 1ns/1ps

module fdc_delay_timer import fdc_pkg::*; (
	input  logic   clk_sys,
	input  logic   rst_n,
	input  logic   load,
	input  delay_t value,
	output logic   done
);

	delay_t count;
	logic   running;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			count   <= '0;
			running <= 1'b0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (load) begin  // reload restarts the wait
				count   <= value;
				running <= 1'b1;
			end else if (running) begin
				count <= count - 1'b1;
				if (count <= delay_t'(1)) begin  // last cycle of the wait
					running <= 1'b0;
					done    <= 1'b1;
				end
			end
		end
	end

endmodule

/* hw/fdc_sector_buffer.sv */
// dual-port block buffer with an image side and a controller side
`timescale 1ns/1ps

module fdc_sector_buffer import fdc_pkg::*; (
	input  logic      clk_sys,
	input  buf_addr_t img_addr,
	input  byte_t     img_wdata,
	input  logic      img_we,
	output byte_t     img_rdata,
	fdc_buf_if.mem    buf_bus
);

	byte_t ram [BLOCK_BYTES];

	// ====================
	// both ports, registered reads
	always_ff @(posedge clk_sys) begin
		if (img_we)
			ram[img_addr] <= img_wdata;  // block fill from the image
		if (buf_bus.we)
			ram[buf_bus.addr] <= buf_bus.wdata;  // host byte during a write
		img_rdata     <= ram[img_addr];
		buf_bus.rdata <= ram[buf_bus.addr];
	end

endmodule

/* hw/fdc_control.sv */
// fdc command decoder, FSM, host registers, status byte and block requests
`timescale 1ns/1ps

module fdc_control import fdc_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      rd,
	input  logic      wr,
	input  reg_addr_t addr,
	input  byte_t     din,
	output byte_t     dout,
	output logic      drq,
	output logic      intrq,
	output logic      busy,
	input  logic      wp,
	input  logic      ready,        // high while no disk is ready
	output logic      sd_rd,
	output logic      sd_wr,
	input  logic      sd_ack,
	output byte_t     track,
	output byte_t     sector,
	input  buf_addr_t buf_offset,
	input  sect_len_t sector_len,
	input  logic      sector_ok,
	output logic      delay_load,
	output delay_t    delay_value,
	input  logic      delay_done,
	fdc_buf_if.ctrl   buf_bus
);

	typedef enum logic [3:0] {
		S_IDLE, S_STEP, S_SEARCH, S_CHECK, S_REQ,
		S_ACK_LOW, S_GAP, S_DRQ, S_NEXT, S_END
	} state_t;

	state_t    state;
	byte_t     cmd_r, track_r, data_r, head_r, status, next_head;
	delay_t    step_wait;
	buf_addr_t ptr;
	sect_len_t remaining;
	logic      step_out, hld, rnf, wr_fault, lost, multi, write_back, go_out;
	logic      is_write, type1_st, data_strb, cmd_strb, tick;

	assign is_write  = cmd_r[7:5] == 3'b101;
	assign type1_st  = !cmd_r[7] || cmd_r[7:4] == 4'hd;  // force int reads like type I
	assign data_strb = drq && (rd || wr) && addr == A_DATA;
	assign cmd_strb  = wr && addr == A_COMMAND;
	assign tick      = delay_done && !delay_load;  // stale pulse while reloading
	assign go_out    = din[6] ? din[5] : step_out;
	assign next_head = !go_out ? head_r + 8'd1 : (head_r != 8'd0 ? head_r - 8'd1 : 8'd0);
	assign track     = head_r;

	assign buf_bus.addr  = ptr;
	assign buf_bus.wdata = din;
	assign buf_bus.we    = state == S_DRQ && data_strb && wr && is_write;

	always_comb begin
		case (din[1:0])  // 6, 12, 20, 30 ms
			2'd0: step_wait = delay_t'(6 * STEP_UNIT);
			2'd1: step_wait = delay_t'(12 * STEP_UNIT);
			2'd2: step_wait = delay_t'(20 * STEP_UNIT);
			default: step_wait = delay_t'(30 * STEP_UNIT);
		endcase
	end

	// ====================
	// status and host read mux
	always_comb begin
		status = '0;
		status[ST_BUSY]        = busy;
		status[ST_DRQ]         = !type1_st && drq;  // no index pulse on type I
		status[ST_LOST_TRK0]   = type1_st ? head_r == 8'd0 : lost;
		status[ST_RNF]         = rnf;
		status[ST_HLD_WRFAULT] = type1_st ? hld : wr_fault;
		status[ST_WPROT]       = (type1_st || is_write) && wp;
		status[ST_NOT_READY]   = ready;
		case (addr)
			A_STATUS: dout = status;
			A_TRACK:  dout = track_r;
			A_SECTOR: dout = sector;
			default:  dout = (busy && !is_write) ? buf_bus.rdata : data_r;
		endcase
	end

	// ====================
	// command FSM
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= S_IDLE;
			cmd_r <= '0;
			track_r <= '0;
			sector <= '0;
			head_r <= '0;
			{busy, drq, intrq, sd_rd, sd_wr, delay_load} <= '0;
			{step_out, hld, rnf, wr_fault, lost, multi, write_back} <= '0;
		end else begin
			delay_load <= 1'b0;
			case (state)
				S_STEP: if (tick) state <= S_END;
				S_SEARCH: state <= S_CHECK;  // locator settles
				S_CHECK: begin
					ptr <= buf_offset;
					remaining <= sector_len;
					if (ready || !sector_ok) begin
						rnf <= !(ready && is_write);
						wr_fault <= ready && is_write;
						state <= S_END;
					end else begin
						sd_rd <= 1'b1;  // whole block first, also before a write
						write_back <= 1'b0;
						state <= S_REQ;
					end
				end
				S_REQ: if (sd_ack) begin
					sd_rd <= 1'b0;
					sd_wr <= 1'b0;
					state <= S_ACK_LOW;
				end
				S_ACK_LOW: if (!sd_ack) begin
					delay_load <= !write_back;
					delay_value <= delay_t'(BYTE_GAP);
					state <= write_back ? S_NEXT : S_GAP;
				end
				S_GAP: if (tick) begin
					drq <= 1'b1;
					delay_load <= 1'b1;
					delay_value <= delay_t'(WATCHDOG_CYCLES);
					state <= S_DRQ;
				end
				S_DRQ: if (data_strb || tick) begin
					drq <= 1'b0;
					if (!data_strb)
						lost <= 1'b1;  // byte skipped
					ptr <= ptr + 1'b1;
					remaining <= remaining - 1'b1;
					if (remaining != sect_len_t'(1)) begin
						delay_load <= 1'b1;
						delay_value <= delay_t'(BYTE_GAP);
						state <= S_GAP;
					end else begin
						sd_wr <= is_write;
						write_back <= is_write;
						state <= is_write ? S_REQ : S_NEXT;
					end
				end
				S_NEXT: begin  // multi-sector runs until the range check fails
					if (multi)
						sector <= sector + 8'd1;
					state <= multi ? S_SEARCH : S_END;
				end
				S_END: begin
					{busy, drq, sd_rd, sd_wr} <= '0;
					intrq <= 1'b1;
					state <= S_IDLE;
				end
				default: ;
			endcase

			if (rd && addr == A_STATUS)
				intrq <= 1'b0;
			if (wr && addr == A_TRACK && !busy)
				track_r <= din;
			if (wr && addr == A_SECTOR && !busy)
				sector <= din;
			if (wr && addr == A_DATA)
				data_r <= din;

			if (cmd_strb) begin
				intrq <= 1'b0;
				if (din[7:4] == 4'hd) begin  // force interrupt
					cmd_r <= din;
					{rnf, wr_fault, lost} <= '0;
					if (state != S_IDLE)
						state <= S_END;
				end else if (state == S_IDLE && !din[7]) begin
					cmd_r <= din;
					{rnf, wr_fault, lost} <= '0;
					busy <= 1'b1;
					hld <= din[3];
					delay_load <= 1'b1;
					delay_value <= step_wait;
					state <= S_STEP;
					if (din[6:4] == 3'b000) begin  // restore
						head_r <= '0;
						track_r <= '0;
					end else if (din[6:4] == 3'b001) begin  // seek
						head_r <= data_r;
						track_r <= data_r;
					end else begin
						if (din[6])
							step_out <= din[5];
						head_r <= next_head;
						if (din[4])
							track_r <= next_head;
					end
				end else if (state == S_IDLE && din[7:6] == 2'b10) begin
					cmd_r <= din;
					{rnf, wr_fault, lost} <= '0;
					busy <= 1'b1;
					multi <= din[4];
					wr_fault <= wp && din[5];  // protected disk never touches the image
					state <= (wp && din[5]) ? S_END : S_SEARCH;
				end
			end
		end
	end

endmodule

/* hw/fdc_top.sv */
// fdc top level joining control, locator, delay timer and sector buffer
`timescale 1ns/1ps

module fdc_top import fdc_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	// host register port
	input  logic       rd,
	input  logic       wr,
	input  reg_addr_t  addr,
	input  byte_t      din,
	output byte_t      dout,
	output logic       drq,
	output logic       intrq,
	output logic       busy,
	// drive state
	input  logic       wp,
	input  logic       ready,
	input  size_code_t size_code,
	// image block port
	output lba_t       sd_lba,
	output logic       sd_rd,
	output logic       sd_wr,
	input  logic       sd_ack,
	input  buf_addr_t  sd_buff_addr,
	input  byte_t      sd_buff_dout,
	input  logic       sd_buff_wr,
	output byte_t      sd_buff_din
);

	byte_t     track;
	byte_t     sector;
	buf_addr_t buf_offset;
	sect_len_t sector_len;
	logic      sector_ok;
	logic      delay_load;
	delay_t    delay_value;
	logic      delay_done;

	fdc_buf_if buf_link ();

	fdc_control u_control (
		.clk_sys, .rst_n, .rd, .wr, .addr, .din, .dout,
		.drq, .intrq, .busy, .wp, .ready,
		.sd_rd, .sd_wr, .sd_ack,
		.track, .sector, .buf_offset, .sector_len, .sector_ok,
		.delay_load, .delay_value, .delay_done,
		.buf_bus (buf_link.ctrl)
	);

	fdc_locator u_locator (
		.clk_sys, .track, .sector, .size_code,
		.lba (sd_lba), .buf_offset, .sector_len, .sector_ok
	);

	fdc_delay_timer u_timer (
		.clk_sys, .rst_n,
		.load  (delay_load),
		.value (delay_value),
		.done  (delay_done)
	);

	// image side runs straight off the sd_buff port
	fdc_sector_buffer u_buffer (
		.clk_sys,
		.img_addr  (sd_buff_addr),
		.img_wdata (sd_buff_dout),
		.img_we    (sd_buff_wr),
		.img_rdata (sd_buff_din),
		.buf_bus   (buf_link.mem)
	);

endmodule

/* verif/sd_image_model.sv */
// behavioral disk image answering block read and write requests
`timescale 1ns/1ps

module sd_image_model import fdc_pkg::*; (
	input  logic      clk_sys,
	input  lba_t      sd_lba,
	input  logic      sd_rd,
	input  logic      sd_wr,
	output logic      sd_ack,
	output buf_addr_t sd_buff_addr,
	output byte_t     sd_buff_dout,
	output logic      sd_buff_wr,
	input  byte_t     sd_buff_din
);

	byte_t  mem [65536];  // 128 blocks of image
	lba_t   last_lba;
	int     rd_count;
	int     wr_count;
	int     i;
	integer seed;

	initial begin
		seed = 32'h5c7b;
		for (i = 0; i < 65536; i++)
			mem[i] = byte_t'($random(seed));
		rd_count = 0;
		wr_count = 0;
		last_lba = '0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
	end

	// ====================
	// one request per ack window
	always begin
		@(posedge clk_sys);
		if (sd_rd || sd_wr) begin
			last_lba = sd_lba;
			sd_ack <= 1'b1;
			if (sd_wr) begin
				wr_count++;
				for (i = 0; i < BLOCK_BYTES; i++) begin
					sd_buff_addr <= buf_addr_t'(i);
					@(posedge clk_sys);
					@(negedge clk_sys);  // buffer read is registered
					mem[{last_lba[6:0], buf_addr_t'(i)}] = sd_buff_din;
				end
			end else begin
				rd_count++;
				for (i = 0; i < BLOCK_BYTES; i++) begin
					sd_buff_addr <= buf_addr_t'(i);
					sd_buff_dout <= mem[{last_lba[6:0], buf_addr_t'(i)}];
					sd_buff_wr <= 1'b1;
					@(posedge clk_sys);
				end
				sd_buff_wr <= 1'b0;
			end
			sd_ack <= 1'b0;
			@(posedge clk_sys);  // controller sees ack low
		end
	end

endmodule

/* verif/fdc_tb.sv */
// fdc testbench with clock, reset, random stimulus, image reference model and report
`timescale 1ns/1ps

module fdc_tb import fdc_pkg::*; ();

	logic       clk_sys, rst_n, rd, wr, drq, intrq, busy, wp, ready;
	logic       sd_rd, sd_wr, sd_ack, sd_buff_wr;
	reg_addr_t  addr;
	byte_t      din, dout, sd_buff_dout, sd_buff_din;
	size_code_t size_code;
	lba_t       sd_lba;
	buf_addr_t  sd_buff_addr;

	byte_t      shadow [65536];  // reference copy of the image
	byte_t      wdata [BLOCK_BYTES];
	byte_t      st, rb, cmd;
	size_code_t code;
	integer     seed;
	int         data_errs, lba_errs, status_errs, other_errs;
	int         i, t, s, k, off, blk, track_m, kind, rd_before, wr_before;
	logic       dir_out;

	fdc_top uut (.*);
	sd_image_model img (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ====================
	// geometry rules
	function automatic int spt_of(input size_code_t c);
		return c == 2'd0 ? 26 : (c == 2'd1 ? 16 : 9);
	endfunction

	function automatic int len_of(input size_code_t c);
		return c == 2'd0 ? 128 : (c == 2'd1 ? 256 : 512);
	endfunction

	function automatic int image_offset(input size_code_t c, input int trk, input int sec);
		return (trk * spt_of(c) + sec - 1) * len_of(c);
	endfunction

	// ====================
	// checks and report
	task automatic check_byte(input string what, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", what, got, exp);
			data_errs++;
		end
	endtask

	task automatic check_lba(input string what, input lba_t got, input lba_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", what, got, exp);
			lba_errs++;
		end
	endtask

	task automatic check_status(input string what, input byte_t got, input byte_t exp,
			input byte_t mask);
		if ((got & mask) !== (exp & mask)) begin
			$display("MISMATCH %s: got %h, expected %h under mask %h", what, got, exp, mask);
			status_errs++;
		end
	endtask

	task automatic report_counts();
		$display("errors: data %0d, lba %0d, status %0d, other %0d",
			data_errs, lba_errs, status_errs, other_errs);
	endtask

	task automatic timeout_fail(input string why);
		$display("TIMEOUT: %s", why);
		report_counts();
		$display("Testbench failed");
		$finish;
	endtask

	// ====================
	// host bus
	task automatic reg_write(input reg_addr_t a, input byte_t d);
		@(posedge clk_sys);
		addr <= a;
		din  <= d;
		wr   <= 1'b1;
		@(posedge clk_sys);
		wr <= 1'b0;
	endtask

	task automatic reg_read(input reg_addr_t a, output byte_t d);
		@(posedge clk_sys);
		addr <= a;
		rd   <= 1'b1;
		@(negedge clk_sys);
		d = dout;
		@(posedge clk_sys);
		rd <= 1'b0;
	endtask

	task automatic wait_drq();
		int n;
		for (n = 0; n < 5000; n++) begin
			@(negedge clk_sys);
			if (drq)
				break;
		end
		if (!drq)
			timeout_fail("drq did not rise for the next byte");
	endtask

	task automatic wait_intrq(input int limit, input bit drq_ok);
		int n;
		bit extra;
		extra = 1'b0;
		for (n = 0; n < limit; n++) begin
			@(negedge clk_sys);
			if (drq && !drq_ok)
				extra = 1'b1;
			if (intrq)
				break;
		end
		if (extra) begin
			$display("ERROR: drq rose after the last expected byte");
			other_errs++;
		end
		if (!intrq)
			timeout_fail("intrq did not rise at the end of a command");
	endtask

	// ====================
	// command helpers
	task automatic issue_type1(input byte_t c, input int exp_track, input byte_t exp_st,
			input byte_t mask);
		byte_t rate;
		byte_t got;
		rate = byte_t'($random(seed)) & 8'h03;
		reg_write(A_COMMAND, c | rate);
		wait_intrq(2000, 1'b0);
		reg_read(A_STATUS, st);
		check_status("type I status", st, exp_st, mask | 8'h01);
		reg_read(A_TRACK, got);
		check_byte("track", got, byte_t'(exp_track));
	endtask

	task automatic pick_sector(output size_code_t c, output int trk, output int sec);
		c = size_code_t'($random(seed));
		trk = {$random(seed)} % 14;  // keeps the image inside 64 KB
		sec = 1 + {$random(seed)} % spt_of(c);
	endtask

	task automatic locate(input size_code_t c, input int trk, input int sec);
		@(posedge clk_sys);
		size_code <= c;
		reg_write(A_DATA, byte_t'(trk));
		issue_type1(8'h10, trk, 8'h00, 8'h01);  // seek
		reg_write(A_SECTOR, byte_t'(sec));
	endtask

	task automatic read_bytes(input int start, input int len);
		int j;
		byte_t got;
		for (j = 0; j < len; j++) begin
			wait_drq();
			reg_read(A_DATA, got);
			check_byte("data", got, shadow[start + j]);
		end
	endtask

	task automatic finish_type2(input string what, input byte_t exp_st, input byte_t mask);
		wait_intrq(5000, 1'b0);
		reg_read(A_STATUS, st);
		check_status(what, st, exp_st, mask);
	endtask

	// ====================
	// main sequence
	initial begin
		seed = 32'h5c7b;
		for (i = 0; i < 65536; i++)  // same fill as the image model
			shadow[i] = byte_t'($random(seed));
		{data_errs, lba_errs, status_errs, other_errs} = '0;
		rst_n = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		addr = A_STATUS;
		din = '0;
		wp = 1'b0;
		ready = 1'b0;
		size_code = '0;
		repeat (8) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		check_status("sd_wr/sd_rd/intrq/drq/busy", byte_t'({sd_wr, sd_rd, intrq, drq, busy}),
			8'h00, 8'h1f);
		reg_read(A_TRACK, rb);
		check_byte("track after reset", rb, 8'h00);
		reg_read(A_SECTOR, rb);
		check_byte("sector after reset", rb, 8'h00);

		// type I: restore, seek, random steps with update
		issue_type1(8'h08, 0, 8'h24, 8'h25);  // head loaded, track 0
		track_m = {$random(seed)} % (MAX_TRACK + 1);
		reg_write(A_DATA, byte_t'(track_m));
		issue_type1(8'h10, track_m, 8'h00, 8'h01);
		dir_out = 1'b0;
		repeat (6) begin
			kind = {$random(seed)} % 3;
			if (kind == 0)
				dir_out = 1'b0;
			else if (kind == 1)
				dir_out = 1'b1;
			if (dir_out)
				track_m = track_m > 0 ? track_m - 1 : 0;
			else
				track_m = track_m + 1;
			cmd = kind == 0 ? 8'h58 : (kind == 1 ? 8'h78 : 8'h38);
			issue_type1(cmd, track_m, track_m == 0 ? 8'h04 : 8'h00, 8'h05);
		end
		// restore from an outer track
		reg_write(A_DATA, 8'h30);
		issue_type1(8'h10, 48, 8'h00, 8'h05);
		issue_type1(8'h08, 0, 8'h24, 8'h25);

		// single sector reads
		repeat (3) begin
			pick_sector(code, t, s);
			locate(code, t, s);
			off = image_offset(code, t, s);
			reg_write(A_COMMAND, 8'h80);
			read_bytes(off, len_of(code));
			finish_type2("read status", 8'h00, 8'hff);
			check_lba("sd_lba", img.last_lba, lba_t'(off >> 9));
		end

		// write, block compare, read back
		pick_sector(code, t, s);
		locate(code, t, s);
		off = image_offset(code, t, s);
		for (i = 0; i < len_of(code); i++)
			wdata[i] = byte_t'($random(seed));
		reg_write(A_COMMAND, 8'hA0);
		for (i = 0; i < len_of(code); i++) begin
			wait_drq();
			reg_write(A_DATA, wdata[i]);
		end
		finish_type2("write status", 8'h00, 8'hff);
		check_lba("sd_lba on write", img.last_lba, lba_t'(off >> 9));
		for (i = 0; i < len_of(code); i++)
			shadow[off + i] = wdata[i];
		blk = off - off % BLOCK_BYTES;
		for (i = 0; i < BLOCK_BYTES; i++)
			check_byte("image byte", img.mem[blk + i], shadow[blk + i]);
		reg_write(A_COMMAND, 8'h80);
		read_bytes(off, len_of(code));
		finish_type2("read back status", 8'h00, 8'hff);

		// multi-sector read to the end of the track
		pick_sector(code, t, s);
		s = spt_of(code) - {$random(seed)} % 3;
		locate(code, t, s);
		reg_write(A_COMMAND, 8'h90);
		for (k = s; k <= spt_of(code); k++)
			read_bytes(image_offset(code, t, k), len_of(code));
		finish_type2("multi-sector status", 8'h10, 8'h13);

		// write protect
		pick_sector(code, t, s);
		locate(code, t, s);
		@(posedge clk_sys);
		wp <= 1'b1;
		wr_before = img.wr_count;
		reg_write(A_COMMAND, 8'hA0);
		finish_type2("protected write status", 8'h60, 8'h61);
		if (img.wr_count != wr_before) begin
			$display("ERROR: image write request issued on a write-protected disk");
			other_errs++;
		end
		@(posedge clk_sys);
		wp <= 1'b0;

		// sector out of range, both ends
		for (k = 0; k < 2; k++) begin
			reg_write(A_SECTOR, k == 0 ? 8'h00 : byte_t'(spt_of(code) + 1));
			rd_before = img.rd_count;
			reg_write(A_COMMAND, 8'h80);
			finish_type2("range check status", 8'h10, 8'h11);
			if (img.rd_count != rd_before) begin
				$display("ERROR: image read request issued for an illegal sector");
				other_errs++;
			end
		end

		// drive not ready
		reg_write(A_SECTOR, byte_t'(s));
		@(posedge clk_sys);
		ready <= 1'b1;
		rd_before = img.rd_count;
		reg_write(A_COMMAND, 8'h80);
		finish_type2("not ready status", 8'h90, 8'h91);
		if (img.rd_count != rd_before) begin
			$display("ERROR: image read request issued while the drive was not ready");
			other_errs++;
		end
		@(posedge clk_sys);
		ready <= 1'b0;

		// force interrupt in the middle of a read
		reg_write(A_COMMAND, 8'h80);
		wait_drq();
		reg_write(A_COMMAND, 8'hD0);
		wait_intrq(100, 1'b1);
		check_status("intrq/drq/busy after abort", byte_t'({intrq, drq, busy}), 8'h04, 8'h07);
		reg_read(A_STATUS, st);

		// unserved DRQs, watchdog skips every byte
		locate(2'd0, 3, 5);
		reg_write(A_COMMAND, 8'h80);
		wait_intrq(80000, 1'b1);
		reg_read(A_STATUS, st);
		check_status("lost data status", st, 8'h04, 8'h05);

		report_counts();
		if (data_errs + lba_errs + status_errs + other_errs == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* verilog.f */
hw/fdc_pkg.sv
hw/fdc_buf_if.sv
hw/fdc_locator.sv
hw/fdc_delay_timer.sv
hw/fdc_sector_buffer.sv
hw/fdc_control.sv
hw/fdc_top.sv
verif/sd_image_model.sv
verif/fdc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fdc_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
